// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ==============================
    // widths
    // ==============================

    // one compressed parcel
    localparam int HALF_W = 16;

    // full instruction and memory word
    localparam int WORD_W = 32;

    // ==============================
    // queue sizing
    // ==============================

    // halfword slots in the fetch queue
    // two words in flight would overrun this, so the controller keeps one
    localparam int FIFO_DEPTH = 5;

    // ==============================
    // instruction constants
    // ==============================

    // addi x0, x0, 0
    // shown to decode whenever the head is not complete
    localparam logic [WORD_W-1:0] NOP_INSTR = 32'h00000013;

    // ==============================
    // controller states
    // ==============================

    // WARMUP  fixed delay after reset release
    // IDLE    stopped, waiting for a redirect
    // FETCH   issuing reads while the queue has room
    // FLUSH   single cycle after a flush request
    typedef enum logic [1:0] {
        WARMUP = 2'd0,
        IDLE   = 2'd1,
        FETCH  = 2'd2,
        FLUSH  = 2'd3
    } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl #(
    parameter logic [fetch_pkg::WORD_W-1:0] RESET_PC   = '0,
    parameter int                           FIFO_DEPTH = fetch_pkg::FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            redirect_i,
    input  logic                            flush_i,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
    input  logic                            rdata_valid_i,
    output logic                            pc_load_o,
    output logic                            pc_inc_o,
    output logic                            mem_re_o,
    output logic                            q_clear_o,
    output logic                            q_drop_first_o,
    output logic                            discard_o
);
    import fetch_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic         warm_cnt_q;
    logic         warm_done;
    logic         in_flight_q;
    logic [CW:0]  committed;
    logic         space_ok;

    // ==============================
    // space accounting
    // ==============================

    // queued halfwords plus the two still on their way
    assign committed = {1'b0, fifo_count_i} + (in_flight_q ? (CW+1)'(2) : '0);
    assign space_ok  = committed <= (CW+1)'(FIFO_DEPTH - 2);

    // no read in a redirect or flush cycle, the counter is about to move
    assign mem_re_o  = (state_q == FETCH) && !redirect_i && !flush_i && space_ok;
    assign pc_inc_o  = mem_re_o;
    assign pc_load_o = redirect_i;
    assign q_clear_o = redirect_i | flush_i;

    // returning word overtaken by a redirect or flush
    assign discard_o = rdata_valid_i & in_flight_q & (redirect_i | flush_i);

    // ==============================
    // state machine
    // ==============================

    assign warm_done = warm_cnt_q;

    // reset pc on an upper halfword, skip the lower one of the first word
    assign q_drop_first_o = (state_q == WARMUP) && warm_done && !redirect_i && RESET_PC[1];

    always_comb begin
        state_d = state_q;
        case (state_q)
            WARMUP: begin
                if (warm_done) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (flush_i) begin
                    state_d = FLUSH;
                end
            end
            FLUSH, IDLE: begin
                if (flush_i) begin
                    state_d = FLUSH;
                end else if (redirect_i) begin
                    state_d = FETCH;
                end else begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= WARMUP;
            warm_cnt_q  <= 1'b0;
            in_flight_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // two warm-up cycles
            if (state_q == WARMUP) begin
                warm_cnt_q <= 1'b1;
            end
            // set on issue, released when the word shows up
            if (mem_re_o) begin
                in_flight_q <= 1'b1;
            end else if (rdata_valid_i) begin
                in_flight_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_pc_counter.sv
`default_nettype none

module fetch_pc_counter #(
    parameter logic [fetch_pkg::WORD_W-1:0] RESET_PC  = '0,
    parameter int                           MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          load_i,
    input  logic [fetch_pkg::WORD_W-1:0]  load_pc_i,
    input  logic                          inc_i,
    output logic [$clog2(MEM_WORDS)-1:0]  word_addr_o
);

    localparam int AW = $clog2(MEM_WORDS);

    // ==============================
    // word address register
    // ==============================

    // byte pc to word index, bits 1:0 are the queue's business
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // first fetch after warm-up comes from here
            word_addr_o <= RESET_PC[AW+1:2];
        end else if (load_i) begin
            word_addr_o <= load_pc_i[AW+1:2];
        end else if (inc_i) begin
            // wrap at the end of the memory
            if (word_addr_o == AW'(MEM_WORDS - 1)) begin
                word_addr_o <= '0;
            end else begin
                word_addr_o <= word_addr_o + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/instr_mem.sv
`default_nettype none

module instr_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          re_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  raddr_i,
    input  logic                          we_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  waddr_i,
    input  logic [fetch_pkg::WORD_W-1:0]  wdata_i,
    output logic [fetch_pkg::WORD_W-1:0]  rdata_o,
    output logic                          rdata_valid_o
);
    import fetch_pkg::*;

    // ==============================
    // storage
    // ==============================

    logic [WORD_W-1:0] mem_q [MEM_WORDS];

    // load port, used before reset release
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // ==============================
    // read port
    // ==============================

    // one cycle read, data holds when re is low
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

    // strobe follows the request
    always_ff @(posedge clk) begin
        rdata_valid_o <= re_i;
    end

endmodule

`default_nettype wire

// File: hw/halfword_fifo.sv
`default_nettype none

module halfword_fifo #(
    parameter logic [fetch_pkg::WORD_W-1:0] RESET_PC = '0
) (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic                                       push_i,
    input  logic [fetch_pkg::WORD_W-1:0]               push_data_i,
    input  logic                                       discard_i,
    input  logic                                       clear_i,
    input  logic                                       drop_first_i,
    input  logic                                       take_i,
    input  logic [fetch_pkg::WORD_W-1:0]               redirect_pc_i,
    input  logic                                       redirect_i,
    output logic [$clog2(fetch_pkg::FIFO_DEPTH+1)-1:0] count_o,
    output logic [fetch_pkg::WORD_W-1:0]               instr_o,
    output logic                                       instr_valid_o,
    output logic [fetch_pkg::WORD_W-1:0]               instr_pc_o
);
    import fetch_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [HALF_W-1:0] entry_q [FIFO_DEPTH];
    logic [HALF_W-1:0] entry_d [FIFO_DEPTH];
    logic [CW-1:0]     count_q;
    logic [CW-1:0]     keep_n;
    logic [1:0]        drain_n;
    logic [1:0]        push_n;
    logic              drop_q;
    logic              push_ok;
    logic              head_comp;
    logic              head_valid;
    logic [HALF_W-1:0] half_a;
    logic [HALF_W-1:0] half_b;
    logic [WORD_W-1:0] pc_q;

    // ==============================
    // head alignment
    // ==============================

    // low bits 11 mean a full 32-bit instruction
    assign head_comp  = entry_q[0][1:0] != 2'b11;
    assign head_valid = head_comp ? (count_q >= CW'(1)) : (count_q >= CW'(2));

    // entry 0 holds the lower parcel
    assign instr_o = !head_valid ? NOP_INSTR :
                     head_comp   ? {{HALF_W{1'b0}}, entry_q[0]} :
                                   {entry_q[1], entry_q[0]};
    assign instr_valid_o = head_valid;
    assign instr_pc_o    = pc_q;
    assign count_o       = count_q;

    // one parcel for compressed, two otherwise
    assign drain_n = (take_i && head_valid) ? (head_comp ? 2'd1 : 2'd2) : 2'd0;

    // ==============================
    // push side
    // ==============================

    assign push_ok = push_i & ~discard_i & ~clear_i;

    // little endian, lower halfword first unless it is skipped
    assign half_a = drop_q ? push_data_i[WORD_W-1:HALF_W] : push_data_i[HALF_W-1:0];
    assign half_b = push_data_i[WORD_W-1:HALF_W];
    assign push_n = !push_ok ? 2'd0 : (drop_q ? 2'd1 : 2'd2);

    // entries left after the drain, new ones go right behind them
    assign keep_n = count_q - CW'(drain_n);

    always_comb begin
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            // shift toward the head
            if (drain_n == 2'd2 && i < FIFO_DEPTH - 2) begin
                entry_d[i] = entry_q[(i + 2) % FIFO_DEPTH];
            end else if (drain_n == 2'd1 && i < FIFO_DEPTH - 1) begin
                entry_d[i] = entry_q[(i + 1) % FIFO_DEPTH];
            end else begin
                entry_d[i] = entry_q[i];
            end
            // append after the survivors
            if (push_n != 2'd0 && CW'(i) == keep_n) begin
                entry_d[i] = half_a;
            end
            if (push_n == 2'd2 && CW'(i) == keep_n + CW'(1)) begin
                entry_d[i] = half_b;
            end
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= entry_d;
    end

    // ==============================
    // count, drop flag, head pc
    // ==============================

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            drop_q  <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            if (clear_i) begin
                count_q <= '0;
            end else begin
                count_q <= keep_n + CW'(push_n);
            end

            // pending skip of the lower halfword of the next word
            if (clear_i) begin
                drop_q <= redirect_i & redirect_pc_i[1];
            end else if (drop_first_i) begin
                drop_q <= 1'b1;
            end else if (push_ok) begin
                drop_q <= 1'b0;
            end

            // head pc follows the target, then steps per take
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (drain_n != 2'd0) begin
                pc_q <= pc_q + (head_comp ? WORD_W'(2) : WORD_W'(4));
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter logic [fetch_pkg::WORD_W-1:0] RESET_PC  = '0,
    parameter int                           MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    // memory load port
    input  logic                          load_we_i,
    input  logic [$clog2(MEM_WORDS)-1:0]  load_addr_i,
    input  logic [fetch_pkg::WORD_W-1:0]  load_data_i,
    // control from later stages
    input  logic                          redirect_i,
    input  logic [fetch_pkg::WORD_W-1:0]  redirect_pc_i,
    input  logic                          flush_i,
    input  logic                          take_i,
    // to decode
    output logic [fetch_pkg::WORD_W-1:0]  instr_o,
    output logic                          instr_valid_o,
    output logic [fetch_pkg::WORD_W-1:0]  instr_pc_o
);
    import fetch_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic              pc_load;
    logic              pc_inc;
    logic              mem_re;
    logic              q_clear;
    logic              q_drop_first;
    logic              discard;
    logic [AW-1:0]     word_addr;
    logic [WORD_W-1:0] rdata;
    logic              rdata_valid;
    logic [CW-1:0]     fifo_count;

    // ==============================
    // sequencing
    // ==============================

    fetch_ctrl #(
        .RESET_PC   (RESET_PC),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .redirect_i     (redirect_i),
        .flush_i        (flush_i),
        .fifo_count_i   (fifo_count),
        .rdata_valid_i  (rdata_valid),
        .pc_load_o      (pc_load),
        .pc_inc_o       (pc_inc),
        .mem_re_o       (mem_re),
        .q_clear_o      (q_clear),
        .q_drop_first_o (q_drop_first),
        .discard_o      (discard)
    );

    // word address, loaded straight from the redirect target
    fetch_pc_counter #(
        .RESET_PC  (RESET_PC),
        .MEM_WORDS (MEM_WORDS)
    ) u_pc (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_i      (pc_load),
        .load_pc_i   (redirect_pc_i),
        .inc_i       (pc_inc),
        .word_addr_o (word_addr)
    );

    // ==============================
    // memory and queue
    // ==============================

    instr_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk           (clk),
        .re_i          (mem_re),
        .raddr_i       (word_addr),
        .we_i          (load_we_i),
        .waddr_i       (load_addr_i),
        .wdata_i       (load_data_i),
        .rdata_o       (rdata),
        .rdata_valid_o (rdata_valid)
    );

    halfword_fifo #(
        .RESET_PC (RESET_PC)
    ) u_fifo (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .push_i        (rdata_valid),
        .push_data_i   (rdata),
        .discard_i     (discard),
        .clear_i       (q_clear),
        .drop_first_i  (q_drop_first),
        .take_i        (take_i),
        .redirect_pc_i (redirect_pc_i),
        .redirect_i    (redirect_i),
        .count_o       (fifo_count),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .instr_pc_o    (instr_pc_o)
    );

endmodule

`default_nettype wire

// File: bench/fetch_properties.sv
`default_nettype none

module fetch_properties (
    input logic                                       clk,
    input logic                                       rst_n_i,
    input logic [$clog2(fetch_pkg::FIFO_DEPTH+1)-1:0] count_i,
    input logic [fetch_pkg::WORD_W-1:0]               instr_i,
    input logic                                       instr_valid_i,
    input fetch_pkg::fetch_state_e                    state_i,
    input logic                                       mem_re_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    // queue occupancy bound
    count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n_i) count_i <= FIFO_DEPTH
    ) else $error("queue count %0d above depth", count_i);

    // empty head shows the nop
    nop_when_invalid: assert property (
        @(posedge clk) disable iff (!rst_n_i) !instr_valid_i |-> instr_i == NOP_INSTR
    ) else $error("invalid head shows %08h", instr_i);

    // no reads while warming up or flushing
    no_read_stopped: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_i == WARMUP || state_i == FLUSH) |-> !mem_re_i
    ) else $error("read issued in state %0d", state_i);

endmodule

// queue side, controller inputs held quiet
bind halfword_fifo fetch_properties fifo_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .count_i       (count_q),
    .instr_i       (instr_o),
    .instr_valid_i (instr_valid_o),
    .state_i       (fetch_pkg::IDLE),
    .mem_re_i      (1'b0)
);

bind fetch_ctrl fetch_properties ctrl_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .count_i       (fifo_count_i),
    .instr_i       (fetch_pkg::NOP_INSTR),
    .instr_valid_i (1'b0),
    .state_i       (state_q),
    .mem_re_i      (mem_re_o)
);

`default_nettype wire

// File: bench/fetch_checker.sv
`default_nettype none

module fetch_checker (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         take_i,
    input  logic [fetch_pkg::WORD_W-1:0] instr_i,
    input  logic                         instr_valid_i,
    input  logic [fetch_pkg::WORD_W-1:0] instr_pc_i,
    output int                           error_count_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    // earliest valid head is warm-up plus one read
    localparam int WARMUP_CYCLES = 2;
    localparam int READ_LATENCY  = 2;

    logic [WORD_W-1:0] exp_instr_q [$];
    logic [WORD_W-1:0] exp_pc_q [$];
    logic [WORD_W-1:0] want_instr;
    logic [WORD_W-1:0] want_pc;
    logic              idle_watch    = 1'b0;
    int                pending       = 0;
    int                test_checked  = 0;
    int                test_errors   = 0;
    int                total_checked = 0;
    int                total_errors  = 0;
    int                tests_run     = 0;
    int                tests_bad     = 0;
    int                since_rst     = 0;

    assign error_count_o = total_errors;

    // ==============================
    // calls from the testbench
    // ==============================

    task automatic expect_instr(input logic [WORD_W-1:0] word, input logic [WORD_W-1:0] pc);
        exp_instr_q.push_back(word);
        exp_pc_q.push_back(pc);
        pending = exp_instr_q.size();
    endtask

    task automatic watch_idle(input logic on);
        idle_watch = on;
    endtask

    task automatic note_error();
        test_errors  = test_errors + 1;
        total_errors = total_errors + 1;
    endtask

    task automatic finish_test(input int idx);
        if (pending != 0) begin
            $display("test %0d ended with %0d expected instructions missing", idx, pending);
            note_error();
            exp_instr_q.delete();
            exp_pc_q.delete();
            pending = 0;
        end
        tests_run = tests_run + 1;
        if (test_errors != 0) begin
            tests_bad = tests_bad + 1;
            $display("test %0d: %0d checked, FAIL", idx, test_checked);
        end else begin
            $display("test %0d: %0d checked, ok", idx, test_checked);
        end
        test_checked = 0;
        test_errors  = 0;
    endtask

    task automatic report();
        $display("summary: %0d tests, %0d with errors, %0d instructions, %0d errors",
                 tests_run, tests_bad, total_checked, total_errors);
    endtask

    // ==============================
    // compare on each rising edge
    // ==============================

    // inputs change on the falling edge, so these are settled here
    always @(posedge clk) begin
        if (!rst_n_i) begin
            since_rst = 0;
        end else begin
            if (instr_valid_i && since_rst < WARMUP_CYCLES + READ_LATENCY) begin
                $display("instruction valid %0d cycles after reset, before warm-up ended",
                         since_rst);
                note_error();
            end
            // stopped after flush
            if (idle_watch && instr_valid_i) begin
                $display("instruction valid while fetch is stopped after a flush");
                note_error();
            end
            if (idle_watch && instr_i != NOP_INSTR) begin
                $display("Mismatch instr_o: got %08h, expected %08h", instr_i, NOP_INSTR);
                note_error();
            end
            if (take_i && instr_valid_i) begin
                if (pending == 0) begin
                    $display("instruction %08h at %08h taken after the expected list was done",
                             instr_i, instr_pc_i);
                    note_error();
                end else begin
                    want_instr    = exp_instr_q.pop_front();
                    want_pc       = exp_pc_q.pop_front();
                    pending       = exp_instr_q.size();
                    test_checked  = test_checked + 1;
                    total_checked = total_checked + 1;
                    if (instr_i !== want_instr) begin
                        $display("Mismatch instr_o: got %08h, expected %08h", instr_i, want_instr);
                        note_error();
                    end
                    if (instr_pc_i !== want_pc) begin
                        $display("Mismatch instr_pc_o: got %08h, expected %08h",
                                 instr_pc_i, want_pc);
                        note_error();
                    end
                end
            end
            if (since_rst < 1000) begin
                since_rst = since_rst + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_fetch.sv
`default_nettype none

module tb_fetch;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    localparam logic [WORD_W-1:0] RESET_PC    = 32'h0000_0000;
    localparam int                MEM_WORDS   = 256;
    localparam int                AW          = $clog2(MEM_WORDS);
    localparam int                STIM_WORDS  = 128;
    localparam int                IDLE_CYCLES = 8;

    // take modes as coded in the stimulus file
    localparam int MODE_RESET  = 0;
    localparam int MODE_RANDOM = 2;
    localparam int MODE_FLUSH  = 3;

    logic              clk;
    logic              rst_n;
    logic              load_we;
    logic [AW-1:0]     load_addr;
    logic [WORD_W-1:0] load_data;
    logic              redirect;
    logic [WORD_W-1:0] redirect_pc;
    logic              flush;
    logic              take;
    logic [WORD_W-1:0] instr;
    logic              instr_valid;
    logic [WORD_W-1:0] instr_pc;
    int                error_count;

    logic [WORD_W-1:0] stim [STIM_WORDS];
    int                cycles;
    int                cycle_limit;
    int                seed;

    fetch_unit #(
        .RESET_PC  (RESET_PC),
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .load_we_i     (load_we),
        .load_addr_i   (load_addr),
        .load_data_i   (load_data),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .flush_i       (flush),
        .take_i        (take),
        .instr_o       (instr),
        .instr_valid_o (instr_valid),
        .instr_pc_o    (instr_pc)
    );

    fetch_checker chk (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .take_i        (take),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .instr_pc_i    (instr_pc),
        .error_count_o (error_count)
    );

    // ==============================
    // clock and run limit
    // ==============================

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // limit is zero until the stimulus has been read
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, expected instructions never arrived", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // ==============================
    // stimulus helpers
    // ==============================

    // sum of instruction counts over all test records
    function automatic int total_expected();
        int pos;
        int n_tests;
        int sum;
        pos     = 1 + int'(stim[0]);
        n_tests = int'(stim[pos]);
        pos     = pos + 1;
        sum     = 0;
        for (int t = 0; t < n_tests; t++) begin
            sum = sum + int'(stim[pos + 2]);
            pos = pos + 3 + 2 * int'(stim[pos + 2]);
        end
        return sum;
    endfunction

    // one word per cycle through the load port
    task automatic load_program();
        for (int i = 0; i < int'(stim[0]); i++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = AW'(i);
            load_data = stim[1 + i];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    // all tasks below start and end on a falling edge
    task automatic redirect_to(input logic [WORD_W-1:0] target);
        take        = 1'b0;
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    // decode keeps asking after the flush and the stage must stay empty
    task automatic flush_and_wait();
        take  = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        take  = 1'b1;
        chk.watch_idle(1'b1);
        repeat (IDLE_CYCLES) @(negedge clk);
        chk.watch_idle(1'b0);
    endtask

    task automatic start_test(input int mode, input logic [WORD_W-1:0] target);
        if (mode == MODE_RESET) begin
            rst_n = 1'b0;
            repeat (3) @(negedge clk);
            rst_n = 1'b1;
        end else begin
            if (mode == MODE_FLUSH) begin
                flush_and_wait();
            end
            redirect_to(target);
        end
    endtask

    // take until every expected instruction is seen or the test budget runs out
    task automatic run_takes(input int mode, input int count);
        int budget;
        budget = 20 * count + 20;
        while (chk.pending > 0 && budget > 0) begin
            take   = (mode == MODE_RANDOM) ? 1'($random(seed)) : 1'b1;
            @(negedge clk);
            budget = budget - 1;
        end
        take = 1'b0;
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        int                pos;
        int                n_tests;
        int                mode;
        int                count;
        logic [WORD_W-1:0] target;
        rst_n       = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        flush       = 1'b0;
        take        = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        seed        = 32'hf8f;
        $readmemh("bench/fetch_stimulus.txt", stim);
        cycle_limit = 20 * total_expected() + 200;
        // load the memory while the stage is held in reset
        load_program();
        pos     = 1 + int'(stim[0]);
        n_tests = int'(stim[pos]);
        pos     = pos + 1;
        for (int t = 0; t < n_tests; t++) begin
            target = stim[pos];
            mode   = int'(stim[pos + 1]);
            count  = int'(stim[pos + 2]);
            pos    = pos + 3;
            start_test(mode, target);
            // expectations queued only once the stage has been restarted
            for (int i = 0; i < count; i++) begin
                chk.expect_instr(stim[pos], stim[pos + 1]);
                pos = pos + 2;
            end
            run_takes(mode, count);
            chk.finish_test(t + 1);
        end
        chk.report();
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fetch_stimulus.txt
// fetch stage stimulus, all values hex
// program: word count, then the words from address 0 up
// then the test count; per test: target pc, take mode, instruction count,
// followed by one line per instruction: expected instr_o, expected instr_pc_o
// take modes: 0 start from reset, 1 continuous, 2 random, 3 flush then redirect
0000000b
00100093 // 0x00 addi x1, x0, 1
00200113 // 0x04 addi x2, x0, 2
00300193 // 0x08 addi x3, x0, 3
00208233 // 0x0c add x4, x1, x2
04054405 // 0x10 c.li then c.addi
03130001 // 0x14 c.nop, low half of a 32-bit at 0x16
84a20050 // 0x18 high half, then c.mv at 0x1a
00600393 // 0x1c addi x7, x0, 6
04130001 // 0x20 c.nop, low half of a 32-bit at 0x22
04850073 // 0x24 high half, then c.addi at 0x26
00940533 // 0x28 add x10, x8, x9
00000005
// test 1 from reset, aligned words
00000000 00000000 00000004
00100093 00000000
00200113 00000004
00300193 00000008
00208233 0000000c
// test 2 mixed widths, one spanning two words
00000010 00000001 00000006
00004405 00000010
00000405 00000012
00000001 00000014
00500313 00000016
000084a2 0000001a
00600393 0000001c
// test 3 target on an upper halfword
00000022 00000001 00000003
00730413 00000022
00000485 00000026
00940533 00000028
// test 4 random back-pressure
00000004 00000002 00000009
00200113 00000004
00300193 00000008
00208233 0000000c
00004405 00000010
00000405 00000012
00000001 00000014
00500313 00000016
000084a2 0000001a
00600393 0000001c
// test 5 flush, then resume mid-word
00000016 00000003 00000005
00500313 00000016
000084a2 0000001a
00600393 0000001c
00000001 00000020
00730413 00000022

// File: build.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/fetch_pc_counter.sv
hw/instr_mem.sv
hw/halfword_fifo.sv
hw/fetch_unit.sv
bench/fetch_properties.sv
bench/fetch_checker.sv
bench/tb_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_fetch -f build.f || exit 1
out=$(./obj_dir/Vtb_fetch)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
